// File: trigger_pkg.sv
package trigger_pkg;

	// Serial word size
	localparam int WORD_BITS = 8;

	// Words in one full sequence
	localparam int PATTERN_LENGTH = 8;

	typedef logic [WORD_BITS-1:0] pattern_word_t;

	typedef logic [$clog2(PATTERN_LENGTH)-1:0] pattern_index_t;

	// Sent in this order, index 0 starts a sequence
	localparam pattern_word_t pattern_table [PATTERN_LENGTH] = '{
		8'hff, // Sequence start
		8'hff,
		8'hf7,
		8'h68,
		8'h80,
		8'h01,
		8'hcc,
		8'haa  // Last word before wrap
	};

endpackage

// File: word_if.sv
`timescale 1ns/1ps

// Four-phase req/ack link carrying one pattern word
interface word_if import trigger_pkg::*; ();

	logic req;
	logic ack;
	pattern_word_t word;
	logic first; // Word is index 0 of the sequence

	modport source (
		output req,
		output word,
		output first,
		input  ack
	);

	modport sink (
		input  req,
		input  word,
		input  first,
		output ack
	);

endinterface

// File: trigger_input_sync.sv
`timescale 1ns/1ps

module trigger_input_sync #(
	parameter int SYNC_STAGES = 2
) (
	input  logic clock,
	input  logic reset1,
	input  logic trigger_in,
	output logic trigger_pulse
);

	logic [SYNC_STAGES-1:0] sync_chain;
	logic last_stage; // One stage past the synchronizer

	// Metastability chain for the asynchronous trigger
	always_ff @(posedge clock) begin
		if (reset1) begin
			sync_chain <= '0;
		end else begin
			sync_chain[0] <= trigger_in;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				sync_chain[i] <= sync_chain[i-1];
			end
		end
	end

	// Rising edge only, a held level gives one pulse
	always_ff @(posedge clock) begin
		if (reset1) begin
			last_stage <= 1'b0;
			trigger_pulse <= 1'b0;
		end else begin
			last_stage <= sync_chain[SYNC_STAGES-1];
			trigger_pulse <= sync_chain[SYNC_STAGES-1] && !last_stage;
		end
	end

endmodule

// File: pattern_sequencer.sv
`timescale 1ns/1ps

module pattern_sequencer
	import trigger_pkg::*;
#(
	parameter int SELF_PERIOD = 64
) (
	input  logic clock,
	input  logic reset1,
	input  logic trigger_pulse,
	input  logic self_triggered,
	output logic trigger_missed,
	word_if.source link
);

	localparam int PERIOD_BITS = $clog2(SELF_PERIOD);
	localparam logic [PERIOD_BITS-1:0] PERIOD_LAST = PERIOD_BITS'(SELF_PERIOD - 1);
	localparam pattern_index_t INDEX_LAST = pattern_index_t'(PATTERN_LENGTH - 1);

	pattern_index_t index;
	pattern_index_t next_index;
	logic [PERIOD_BITS-1:0] period_count;
	logic prev_mode;
	logic mode_change;
	logic period_tick;
	logic link_free;
	logic start;

	assign mode_change = self_triggered != prev_mode;
	assign period_tick = self_triggered && (period_count == PERIOD_LAST);

	// Free only once the previous handshake has fully returned to zero
	assign link_free = !link.req && !link.ack;

	// A mode switch takes priority over any request in the same cycle
	assign start = !mode_change && link_free
		&& (self_triggered ? period_tick : trigger_pulse);

	assign next_index = (index == INDEX_LAST) ? '0 : index + 1'b1;

	// Mode history and self-trigger interval
	always_ff @(posedge clock) begin
		if (reset1) begin
			prev_mode <= 1'b0;
			period_count <= '0;
		end else begin
			prev_mode <= self_triggered;
			if (mode_change || !self_triggered) begin
				period_count <= '0;
			end else if (period_tick) begin
				period_count <= '0; // Ticks are skipped if the link is busy
			end else begin
				period_count <= period_count + 1'b1;
			end
		end
	end

	// Sequence position
	always_ff @(posedge clock) begin
		if (reset1) begin
			index <= '0;
		end else if (mode_change) begin
			index <= '0; // Restart the sequence in the new mode
		end else if (start) begin
			index <= next_index;
		end
	end

	// Source side of the four-phase handshake
	always_ff @(posedge clock) begin
		if (reset1) begin
			link.req <= 1'b0;
		end else if (start) begin
			link.req <= 1'b1;
		end else if (link.req && link.ack) begin
			link.req <= 1'b0;
		end
	end

	// Word and first flag settle on the same edge req rises
	always_ff @(posedge clock) begin
		if (start) begin
			link.word <= pattern_table[index];
			link.first <= (index == '0);
		end
	end

	// No queue, a trigger during a busy link is dropped and reported
	always_ff @(posedge clock) begin
		if (reset1) begin
			trigger_missed <= 1'b0;
		end else begin
			trigger_missed <= !self_triggered && trigger_pulse && !link_free;
		end
	end

endmodule

// File: word_serializer.sv
`timescale 1ns/1ps

module word_serializer
	import trigger_pkg::*;
(
	input  logic clock,
	input  logic reset1,
	word_if.sink link,
	output logic serial_out,
	output logic serial_enable,
	output logic sync_out,
	output pattern_word_t status_word
);

	localparam int COUNT_BITS = $clog2(WORD_BITS + 1);

	pattern_word_t shift_reg;
	logic [COUNT_BITS-1:0] bits_left;
	logic first_flag;
	logic idle;
	logic load;

	assign idle = (bits_left == '0);

	// Accept a word only with the shifter empty and the last handshake closed
	assign load = idle && link.req && !link.ack;

	// Handshake, bit count and status latch
	always_ff @(posedge clock) begin
		if (reset1) begin
			link.ack <= 1'b0;
			bits_left <= '0;
			status_word <= '0;
		end else if (load) begin
			link.ack <= 1'b1;
			bits_left <= COUNT_BITS'(WORD_BITS);
			status_word <= link.word;
		end else begin
			if (link.ack && !link.req) begin
				link.ack <= 1'b0;
			end
			if (!idle) begin
				bits_left <= bits_left - 1'b1;
			end
		end
	end

	// MSB first
	always_ff @(posedge clock) begin
		if (load) begin
			shift_reg <= link.word;
			first_flag <= link.first;
		end else if (!idle) begin
			shift_reg <= {shift_reg[WORD_BITS-2:0], 1'b0};
		end
	end

	assign serial_enable = !idle;
	assign serial_out = serial_enable && shift_reg[WORD_BITS-1];
	assign sync_out = serial_enable && first_flag; // Whole word at index 0

endmodule

// File: trigger_pattern_top.sv
`timescale 1ns/1ps

module trigger_pattern_top
	import trigger_pkg::*;
#(
	parameter int SELF_PERIOD = 64,
	parameter int SYNC_STAGES = 2
) (
	input  logic clock,
	input  logic reset1,
	input  logic trigger_in,     // Asynchronous
	input  logic self_triggered, // Mode select
	output logic serial_out,
	output logic serial_enable,
	output logic sync_out,
	output logic trigger_missed,
	output pattern_word_t status_word
);

	logic trigger_pulse;

	word_if link ();

	trigger_input_sync #(
		.SYNC_STAGES(SYNC_STAGES)
	) u_input_sync (
		.clock(clock),
		.reset1(reset1),
		.trigger_in(trigger_in),
		.trigger_pulse(trigger_pulse)
	);

	pattern_sequencer #(
		.SELF_PERIOD(SELF_PERIOD)
	) u_sequencer (
		.clock(clock),
		.reset1(reset1),
		.trigger_pulse(trigger_pulse),
		.self_triggered(self_triggered),
		.trigger_missed(trigger_missed),
		.link(link.source)
	);

	// Fabric-clock stand-in for the output serializer
	word_serializer u_serializer (
		.clock(clock),
		.reset1(reset1),
		.link(link.sink),
		.serial_out(serial_out),
		.serial_enable(serial_enable),
		.sync_out(sync_out),
		.status_word(status_word)
	);

endmodule

// File: trigger_pattern_props.sv
`timescale 1ns/1ps

module trigger_pattern_props
	import trigger_pkg::*;
(
	input  logic clock,
	input  logic reset1,
	input  logic req,
	input  logic ack,
	input  logic serial_enable
);

	ack_needs_req: assert property (@(posedge clock) disable iff (reset1)
		$rose(ack) |-> req)
		else $error("ack rose while req was low");

	// Source holds the request until it is taken
	req_held: assert property (@(posedge clock) disable iff (reset1)
		req && !ack |=> req)
		else $error("req dropped before ack rose");

	enable_not_long: assert property (@(posedge clock) disable iff (reset1)
		$rose(serial_enable) |-> ##(WORD_BITS) !serial_enable)
		else $error("serial_enable stayed high longer than one word");

	enable_not_short: assert property (@(posedge clock) disable iff (reset1)
		$fell(serial_enable) |-> $past(serial_enable, WORD_BITS))
		else $error("serial_enable fell before a full word");

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker
	import trigger_pkg::*;
#(
	parameter int SELF_PERIOD = 64
) (
	input  logic clock,
	input  logic reset1,
	input  logic self_triggered,
	input  logic serial_out,
	input  logic serial_enable,
	input  logic sync_out,
	input  logic trigger_missed,
	input  pattern_word_t status_word,
	input  logic end_of_test,
	input  int expected_words,
	input  int expected_misses,
	output int error_count,
	output int word_count,
	output int miss_count
);

	int errors = 0;
	int words = 0;
	int misses = 0;
	int cycle = 0;
	int bit_count = 0;
	int last_start = 0;
	logic have_start = 1'b0;
	logic end_checked = 1'b0;
	logic prev_mode = 1'b0;
	logic prev_enable = 1'b0;
	int exp_index = 0;
	pattern_word_t rebuilt = '0;

	assign error_count = errors;
	assign word_count = words;
	assign miss_count = misses;

	task automatic report_word(input string name, input int expected, input int actual);
		$display("Fail at %0t: %s expected %0h got %0h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic report_count(input string name, input int expected, input int actual);
		$display("Fail at %0t: %s expected %0d got %0d", $time, name, expected, actual);
		errors++;
	endtask

	// Self-triggered words must start one period apart
	task automatic check_spacing();
		if (self_triggered && have_start && (cycle - last_start != SELF_PERIOD)) begin
			report_count("self word spacing", SELF_PERIOD, cycle - last_start);
		end
		last_start = cycle;
		have_start = self_triggered;
	endtask

	task automatic check_word();
		if (rebuilt !== pattern_table[exp_index]) begin
			report_word("serial word", int'(pattern_table[exp_index]), int'(rebuilt));
		end
		if (status_word !== pattern_table[exp_index]) begin
			report_word("status_word", int'(pattern_table[exp_index]), int'(status_word));
		end
		words++;
		bit_count = 0;
		exp_index = (exp_index + 1) % PATTERN_LENGTH;
	endtask

	// Falling edge sampling keeps clear of DUT register updates
	always @(negedge clock) begin
		cycle++;
		if (reset1) begin
			if (serial_out !== 1'b0) report_word("serial_out", 0, int'(serial_out));
			if (serial_enable !== 1'b0) report_word("serial_enable", 0, int'(serial_enable));
			if (sync_out !== 1'b0) report_word("sync_out", 0, int'(sync_out));
			if (trigger_missed !== 1'b0) report_word("trigger_missed", 0, int'(trigger_missed));
			if (status_word !== '0) report_word("status_word", 0, int'(status_word));
			exp_index = 0;
			bit_count = 0;
			have_start = 1'b0;
		end else begin
			if (self_triggered != prev_mode) begin
				exp_index = 0; // New mode restarts the sequence
				have_start = 1'b0;
			end
			if (trigger_missed) misses++;
			if (serial_enable) begin
				if (!prev_enable) check_spacing();
				rebuilt = {rebuilt[WORD_BITS-2:0], serial_out}; // MSB arrives first
				bit_count++;
				if (sync_out !== (exp_index == 0)) begin
					report_word("sync_out", int'(exp_index == 0), int'(sync_out));
				end
				if (bit_count == WORD_BITS) check_word();
			end else if (bit_count != 0) begin
				$display("Word cut short at %0t: serial_enable fell after %0d bits",
					$time, bit_count);
				errors++;
				bit_count = 0;
			end else if (sync_out !== 1'b0) begin
				report_word("sync_out", 0, int'(sync_out));
			end
			if (end_of_test && !end_checked) begin
				end_checked = 1'b1;
				if (words != expected_words) report_count("word count", expected_words, words);
				if (misses != expected_misses) begin
					report_count("trigger_missed count", expected_misses, misses);
				end
			end
		end
		prev_mode = self_triggered;
		prev_enable = serial_enable;
	end

endmodule

// File: tb_trigger_pattern.sv
`timescale 1ns/1ps

module tb_trigger_pattern import trigger_pkg::*; ();

	localparam int SELF_PERIOD = 32;
	localparam int RESET_CYCLES = 5;
	localparam int MARGIN = 200;

	typedef struct packed {
		logic mode;       // 1 for self-triggered
		logic close;      // Follows the previous row with no gap
		logic [7:0] rise;
		logic [7:0] high;
		logic [7:0] after;
		logic [3:0] words;
		logic [3:0] misses;
	} row_t;

	logic clock = 1'b0;
	logic reset1;
	logic trigger_in;
	logic self_triggered;
	logic serial_out;
	logic serial_enable;
	logic sync_out;
	logic trigger_missed;
	pattern_word_t status_word;
	logic end_of_test;
	int expected_words = 0;
	int expected_misses = 0;
	int error_count;
	int word_count;
	int miss_count;
	int seed;
	int gap;
	int cycle_count = 0;
	int cycle_limit = 0;
	row_t rows[$];

	always #2 clock = ~clock;

	trigger_pattern_top #(
		.SELF_PERIOD(SELF_PERIOD),
		.SYNC_STAGES(2)
	) uut (
		.clock(clock),
		.reset1(reset1),
		.trigger_in(trigger_in),
		.self_triggered(self_triggered),
		.serial_out(serial_out),
		.serial_enable(serial_enable),
		.sync_out(sync_out),
		.trigger_missed(trigger_missed),
		.status_word(status_word)
	);

	tb_checker #(
		.SELF_PERIOD(SELF_PERIOD)
	) u_checker (
		.clock(clock),
		.reset1(reset1),
		.self_triggered(self_triggered),
		.serial_out(serial_out),
		.serial_enable(serial_enable),
		.sync_out(sync_out),
		.trigger_missed(trigger_missed),
		.status_word(status_word),
		.end_of_test(end_of_test),
		.expected_words(expected_words),
		.expected_misses(expected_misses),
		.error_count(error_count),
		.word_count(word_count),
		.miss_count(miss_count)
	);

	bind word_serializer trigger_pattern_props u_props (
		.clock(clock),
		.reset1(reset1),
		.req(link.req),
		.ack(link.ack),
		.serial_enable(serial_enable)
	);

	function automatic void add_row(input logic mode, input logic close, input int rise,
		input int high, input int after, input int words, input int misses);
		row_t row;
		row.mode = mode;
		row.close = close;
		row.rise = 8'(rise);
		row.high = 8'(high);
		row.after = 8'(after);
		row.words = 4'(words);
		row.misses = 4'(misses);
		rows.push_back(row);
		cycle_limit += rise + high + after;
	endfunction

	// Each step ends 1 ns after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic apply_row(input row_t row);
		self_triggered = row.mode;
		wait_cycles(int'(row.rise));
		if (row.high != 0) begin
			trigger_in = 1'b1;
			wait_cycles(int'(row.high));
			trigger_in = 1'b0;
		end
		wait_cycles(int'(row.after));
		expected_words += int'(row.words);
		expected_misses += int'(row.misses);
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Run timed out after %0d cycles", cycle_count);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		seed = 32'h4c30;
		reset1 = 1'b1;
		trigger_in = 1'b0;
		self_triggered = 1'b0;
		end_of_test = 1'b0;
		cycle_limit = RESET_CYCLES + MARGIN;
		repeat (3) add_row(1'b0, 1'b0, 1, 3, 16, 1, 0);
		add_row(1'b0, 1'b0, 1, 1, 1, 1, 0);
		add_row(1'b0, 1'b1, 0, 1, 18, 0, 1); // Lands inside the previous handshake
		repeat (6) add_row(1'b0, 1'b0, 1, 3, 16, 1, 0); // Wraps past index 7
		add_row(1'b1, 1'b0, 0, 0, SELF_PERIOD * 3 + 16, 3, 0);
		repeat (2) add_row(1'b0, 1'b0, 1, 3, 16, 1, 0);
		wait_cycles(RESET_CYCLES);
		reset1 = 1'b0;
		foreach (rows[i]) begin
			gap = rows[i].close ? 0 : ($random(seed) & 3);
			wait_cycles(gap);
			apply_row(rows[i]);
		end
		wait_cycles(4);
		end_of_test = 1'b1;
		wait_cycles(2);
		$display("Words %0d of %0d, missed triggers %0d of %0d, errors %0d",
			word_count, expected_words, miss_count, expected_misses, error_count);
		if (error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: trigger_pattern_top.f
trigger_pkg.sv
word_if.sv
trigger_input_sync.sv
pattern_sequencer.sv
word_serializer.sv
trigger_pattern_top.sv
trigger_pattern_props.sv
tb_checker.sv
tb_trigger_pattern.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_trigger_pattern
FILELIST  := trigger_pattern_top.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Everything OK" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
